// ==== md_top.f ====
+incdir+design
design/md_pkg.sv
design/md_cmd_if.sv
design/md_issue.sv
design/md_queue.sv
design/md_unit.sv
design/md_top.sv
tests/md_props.sv
tests/md_tb.sv

// ==== Makefile ====
# Verilator build and run of the multiply/divide testbench

OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f md_top.f \
		--top-module md_tb -Mdir $(OBJ_DIR) -o md_tb

# Pass only when the simulation printed the pass line
run: compile
	@out=$$(./$(OBJ_DIR)/md_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/md_tb.sv ====
`timescale 1ns/10ps

module md_tb;
	import md_pkg::*;

	localparam int TIMEOUT = 600;

	logic clk = 1'b0;
	logic reset;
	logic cmd_valid;
	md_op_t cmd_op;
	word_t cmd_rs;
	word_t cmd_rt;
	logic cmd_full;
	logic cmd_error;
	logic result_valid;
	word_t result;
	logic busy;

	// Reference HI/LO and results still due
	word_t ref_hi;
	word_t ref_lo;
	word_t expected [$];
	logic [31:0] lcg_state;
	int errors;
	int timeouts;
	int error_pulses;
	// Falling edges spent held off by cmd_full
	int full_waits;

	md_top dut (.*);

	always #5 clk = ~clk;

	// Operand source
	function automatic word_t next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////
	function automatic void apply_model(input md_op_t op, input word_t rs, input word_t rt);
		logic [63:0] prod_s;
		logic [63:0] prod_u;
		prod_s = longint'($signed(rs)) * longint'($signed(rt));
		prod_u = {32'b0, rs} * {32'b0, rt};
		case (op)
			MD_MTHI: ref_hi = rs;
			MD_MTLO: ref_lo = rs;
			MD_MFHI: expected.push_back(ref_hi);
			MD_MFLO: expected.push_back(ref_lo);
			MD_MUL: expected.push_back(prod_s[31:0]);
			MD_MULT: {ref_hi, ref_lo} = prod_s;
			MD_MULTU: {ref_hi, ref_lo} = prod_u;
			// Quotient truncates toward zero and the remainder follows the dividend
			MD_DIV:
			begin
				ref_lo = word_t'($signed(rs) / $signed(rt));
				ref_hi = word_t'($signed(rs) % $signed(rt));
			end
			MD_DIVU:
			begin
				ref_lo = rs / rt;
				ref_hi = rs % rt;
			end
			default: ;
		endcase
	endfunction

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////
	task automatic send(input md_op_t op, input word_t rs, input word_t rt);
		int waited;
		waited = 0;
		// Back-pressure from the queue
		while (cmd_full && waited < TIMEOUT)
		begin
			@(negedge clk);
			waited++;
			full_waits++;
		end
		if (cmd_full)
		begin
			timeouts++;
			$display("Timeout: queue stayed full at %0t", $time);
		end
		cmd_valid = 1'b1;
		cmd_op = op;
		cmd_rs = rs;
		cmd_rt = rt;
		apply_model(op, rs, rt);
		@(negedge clk);
		cmd_valid = 1'b0;
	endtask

	// Non-zero divisor of varied size that is never minus one
	task automatic divide_random(input md_op_t op);
		word_t shift;
		word_t b;
		shift = next_rand();
		b = word_t'($signed(next_rand()) >>> shift[4:0]);
		if (b == '0 || b == '1)
			b = 32'd7;
		send(op, next_rand(), b);
	endtask

	// Results in order against the model
	always @(posedge clk)
	begin
		if (!reset && cmd_error)
			error_pulses++;
		if (!reset && result_valid)
		begin
			assert (expected.size() > 0)
			else
			begin
				errors++;
				$display("FAIL %0t: unexpected result %h", $time, result);
			end
			if (expected.size() > 0)
			begin
				assert (result == expected[0])
				else
				begin
					errors++;
					$display("FAIL %0t: result %h, expected %h", $time, result, expected[0]);
				end
				void'(expected.pop_front());
			end
		end
	end

	initial
	begin
		int waited;
		int prop_fails;
		lcg_state = 32'h7b61_1d3f;
		errors = 0;
		timeouts = 0;
		error_pulses = 0;
		full_waits = 0;
		ref_hi = '0;
		ref_lo = '0;
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd_op = '0;
		cmd_rs = '0;
		cmd_rt = '0;
		repeat (4) @(negedge clk);
		// Status outputs held low by reset
		assert (!cmd_full && !cmd_error && !result_valid && !busy)
		else
		begin
			errors++;
			$display("FAIL %0t: outputs not low after reset", $time);
		end
		reset = 1'b0;

		// Moves and reads
		for (int i = 0; i < 4; i++)
		begin
			send(MD_MTHI, next_rand(), '0);
			send(MD_MTLO, next_rand(), '0);
			send(MD_MFHI, '0, '0);
			send(MD_MFLO, '0, '0);
		end
		// Full products followed by MUL with HI/LO left alone
		for (int i = 0; i < 8; i++)
		begin
			send((i % 2) ? MD_MULTU : MD_MULT, next_rand(), next_rand());
			send(MD_MFHI, '0, '0);
			send(MD_MFLO, '0, '0);
			send(MD_MUL, next_rand(), next_rand());
			send(MD_MFHI, '0, '0);
			send(MD_MFLO, '0, '0);
		end
		// Signed and unsigned divides
		for (int i = 0; i < 6; i++)
		begin
			divide_random((i % 2) ? MD_DIVU : MD_DIV);
			send(MD_MFHI, '0, '0);
			send(MD_MFLO, '0, '0);
		end
		// Burst queued behind a divide
		full_waits = 0;
		divide_random(MD_DIV);
		for (int i = 0; i < 12; i++)
		begin
			send(MD_MTLO, next_rand(), '0);
			send(MD_MFLO, '0, '0);
			send(MD_MUL, next_rand(), next_rand());
		end
		send(MD_MFHI, '0, '0);
		assert (full_waits > 0)
		else
		begin
			errors++;
			$display("FAIL %0t: burst behind the divide never met cmd_full", $time);
		end

		// Undefined opcode
		send(4'd12, next_rand(), next_rand());
		waited = 0;
		while (error_pulses == 0 && waited < TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		if (error_pulses == 0)
		begin
			timeouts++;
			$display("Timeout: no cmd_error pulse for an undefined opcode");
		end
		send(MD_MFHI, '0, '0);
		send(MD_MFLO, '0, '0);

		// Drain everything still in flight
		waited = 0;
		while ((expected.size() != 0 || busy) && waited < TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		if (expected.size() != 0 || busy)
		begin
			timeouts++;
			$display("Timeout: %0d results never arrived or the unit stayed busy",
				expected.size());
		end
		assert (!cmd_full)
		else
		begin
			errors++;
			$display("FAIL %0t: cmd_full high with the queue drained", $time);
		end
		assert (error_pulses == 1)
		else
		begin
			errors++;
			$display("FAIL %0t: %0d cmd_error pulses, expected 1", $time, error_pulses);
		end

		prop_fails = dut.u_unit.u_props.violations;
		$display("Summary: %0d errors, %0d timeouts, %0d assertion failures",
			errors, timeouts, prop_fails);
		if (errors == 0 && timeouts == 0 && prop_fails == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== tests/md_props.sv ====
`timescale 1ns/10ps
`include "md_config.svh"

module md_props
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	input md_pkg::md_op_t in_op,
	input logic busy,
	input logic result_valid
);
	import md_pkg::*;

	// Busy cycles seen so far in the current divide
	int unsigned busy_run;
	logic div_accept;
	// Failed assertions so far
	int unsigned violations = 0;

	// Divide taken by the idle unit
	assign div_accept = in_valid && !busy && (in_op == MD_DIV || in_op == MD_DIVU);

	always_ff @(posedge clk)
	begin
		if (reset || !busy)
			busy_run <= 0;
		else
			busy_run <= busy_run + 1;
	end

	////////////////////////////////////////
	// Divide timing
	////////////////////////////////////////
	assert property (@(posedge clk) disable iff (reset) div_accept |=> busy)
	else
	begin
		violations++;
		$error("busy did not rise after a divide was accepted");
	end

	// Exactly one busy cycle per divide step
	assert property (@(posedge clk) disable iff (reset)
		$fell(busy) |-> busy_run == `MD_DIV_STEPS)
	else
	begin
		violations++;
		$error("busy fell after %0d cycles", busy_run);
	end
	assert property (@(posedge clk) disable iff (reset) busy |-> busy_run < `MD_DIV_STEPS)
	else
	begin
		violations++;
		$error("busy stayed high past the divide length");
	end

	////////////////////////////////////////
	// Exclusion and reset
	////////////////////////////////////////
	assert property (@(posedge clk) disable iff (reset) busy |-> !in_valid)
	else
	begin
		violations++;
		$error("command strobe arrived while busy");
	end
	assert property (@(posedge clk) disable iff (reset) busy |-> !result_valid)
	else
	begin
		violations++;
		$error("result_valid high while busy");
	end
	assert property (@(posedge clk) reset |=> !busy && !result_valid)
	else
	begin
		violations++;
		$error("unit outputs not low after reset");
	end

endmodule

// Interface members of the unit's command port reach the checker here
bind md_unit md_props u_props
(
	.clk(clk),
	.reset(reset),
	.in_valid(in.valid),
	.in_op(in.op),
	.busy(busy),
	.result_valid(result_valid)
);

// ==== design/md_top.sv ====
`timescale 1ns/10ps

module md_top
(
	input logic clk,
	input logic reset,
	// Command from the pipeline
	input logic cmd_valid,
	input md_pkg::md_op_t cmd_op,
	input md_pkg::word_t cmd_rs,
	input md_pkg::word_t cmd_rt,
	// Back-pressure and status
	output logic cmd_full,
	output logic cmd_error,
	output logic result_valid,
	output md_pkg::word_t result,
	output logic busy
);

	// Issue register to queue
	md_cmd_if issue_q ();
	// Queue head to execution unit
	md_cmd_if queue_u ();

	md_issue u_issue
	(
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_op(cmd_op),
		.cmd_rs(cmd_rs),
		.cmd_rt(cmd_rt),
		.cmd_error(cmd_error),
		.out(issue_q.source)
	);

	// Busy from the unit stalls the queue and goes out as status
	md_queue u_queue
	(
		.clk(clk),
		.reset(reset),
		.in(issue_q.sink),
		.out(queue_u.source),
		.busy(busy),
		.full(cmd_full)
	);

	md_unit u_unit
	(
		.clk(clk),
		.reset(reset),
		.in(queue_u.sink),
		.busy(busy),
		.result_valid(result_valid),
		.result(result)
	);

endmodule

// ==== design/md_unit.sv ====
`timescale 1ns/10ps
`include "md_config.svh"

module md_unit
(
	input logic clk,
	input logic reset,
	md_cmd_if.sink in,
	output logic busy,
	output logic result_valid,
	output md_pkg::word_t result
);
	import md_pkg::*;

	localparam int W = $bits(word_t);
	localparam int CNT_W = $clog2(`MD_DIV_STEPS);

	// Architectural HI and LO
	word_t hi;
	word_t lo;

	md_state_t state;
	// Steps left after the current one
	logic [CNT_W-1:0] step_cnt;

	// Divider working set
	// Remainder in the upper half and quotient shifting into the lower half
	dword_t div_work;
	word_t divisor;
	logic neg_quot;
	logic neg_rem;

	// Products
	dword_t prod_s;
	dword_t prod_u;

	// Divide entry and step values
	logic div_signed;
	word_t rs_mag;
	word_t rt_mag;
	logic [W:0] trial;
	dword_t work_next;
	word_t quot_final;
	word_t rem_final;

	assign busy = (state == st_divide);

	////////////////////////////////////////
	// Multiply
	////////////////////////////////////////

	// Extended operands so the low 2W bits are the exact product
	always_comb
	begin
		prod_s = {{W{in.rs[W-1]}}, in.rs} * {{W{in.rt[W-1]}}, in.rt};
		prod_u = {{W{1'b0}}, in.rs} * {{W{1'b0}}, in.rt};
	end

	////////////////////////////////////////
	// Divide datapath
	////////////////////////////////////////

	// Magnitudes for DIV and raw operands for DIVU
	always_comb
	begin
		div_signed = (in.op == MD_DIV);
		rs_mag = (div_signed && in.rs[W-1]) ? -in.rs : in.rs;
		rt_mag = (div_signed && in.rt[W-1]) ? -in.rt : in.rt;
	end

	// One restoring step
	// Partial remainder is W+1 bits after the shift
	always_comb
	begin
		trial = div_work[2*W-1:W-1] - {1'b0, divisor};
		if (!trial[W])
			work_next = {trial[W-1:0], div_work[W-2:0], 1'b1};
		else
			work_next = {div_work[2*W-2:0], 1'b0};
		// Signs back on for the last step
		quot_final = neg_quot ? -work_next[W-1:0] : work_next[W-1:0];
		rem_final = neg_rem ? -work_next[2*W-1:W] : work_next[2*W-1:W];
	end

	////////////////////////////////////////
	// Control and HI/LO
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_idle;
			step_cnt <= '0;
			hi <= '0;
			lo <= '0;
			result_valid <= 1'b0;
		end
		else
		begin
			result_valid <= 1'b0;
			case (state)
				st_idle:
				begin
					if (in.valid)
					begin
						case (in.op)
							MD_MTHI: hi <= in.rs;
							MD_MTLO: lo <= in.rs;
							MD_MFHI, MD_MFLO, MD_MUL: result_valid <= 1'b1;
							MD_MULT: {hi, lo} <= prod_s;
							MD_MULTU: {hi, lo} <= prod_u;
							MD_DIV, MD_DIVU:
							begin
								state <= st_divide;
								step_cnt <= CNT_W'(`MD_DIV_STEPS - 1);
							end
							default: state <= st_idle;
						endcase
					end
				end
				st_divide:
				begin
					step_cnt <= step_cnt - 1'b1;
					// HI/LO take the signed results on the last step as busy drops
					if (step_cnt == '0)
					begin
						state <= st_idle;
						hi <= rem_final;
						lo <= quot_final;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Result word and divider registers
	always_ff @(posedge clk)
	begin
		if (state == st_idle && in.valid)
		begin
			case (in.op)
				MD_MFHI: result <= hi;
				MD_MFLO: result <= lo;
				MD_MUL: result <= prod_s[W-1:0];
				MD_DIV, MD_DIVU:
				begin
					div_work <= {{W{1'b0}}, rs_mag};
					divisor <= rt_mag;
					// Quotient negative when the signs differ
					neg_quot <= div_signed && (in.rs[W-1] ^ in.rt[W-1]);
					neg_rem <= div_signed && in.rs[W-1];
				end
				default: result <= result;
			endcase
		end
		else if (state == st_divide)
			div_work <= work_next;
	end

endmodule

// ==== design/md_queue.sv ====
`timescale 1ns/10ps
`include "md_config.svh"

module md_queue
(
	input logic clk,
	input logic reset,
	md_cmd_if.sink in,
	md_cmd_if.source out,
	input logic busy,
	output logic full
);
	import md_pkg::*;

	localparam int DEPTH = `MD_QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	// Entry storage
	md_op_t op_mem [DEPTH];
	word_t rs_mem [DEPTH];
	word_t rt_mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	// Occupancy, one bit wider than the pointers
	logic [PTR_W:0] count;
	logic pop;

	// Hold off while a divide runs
	// No pop right after a pop so a new divide can raise busy first
	assign pop = (count != '0) && !busy && !out.valid;

	// Early full level keeps one slot for the command in the issue register
	assign full = (count >= (PTR_W+1)'(DEPTH - 1));

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (in.valid)
		begin
			op_mem[wr_ptr] <= in.op;
			rs_mem[wr_ptr] <= in.rs;
			rt_mem[wr_ptr] <= in.rt;
		end
	end

	////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			out.valid <= 1'b0;
		end
		else
		begin
			if (in.valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Write and pop together leave the count alone
			case ({in.valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			out.valid <= pop;
		end
	end

	// Head entry towards the unit
	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			out.op <= op_mem[rd_ptr];
			out.rs <= rs_mem[rd_ptr];
			out.rt <= rt_mem[rd_ptr];
		end
	end

endmodule

// ==== design/md_issue.sv ====
`timescale 1ns/10ps

module md_issue
(
	input logic clk,
	input logic reset,
	input logic cmd_valid,
	input md_pkg::md_op_t cmd_op,
	input md_pkg::word_t cmd_rs,
	input md_pkg::word_t cmd_rt,
	output logic cmd_error,
	md_cmd_if.source out
);
	import md_pkg::*;

	// Opcode is one the unit can run
	logic op_legal;

	////////////////////////////////////////
	// Decode
	////////////////////////////////////////

	// Only the nine defined codes pass
	always_comb
	begin
		op_legal = cmd_op inside {MD_DIV, MD_DIVU, MD_MFHI, MD_MFLO, MD_MTHI,
			MD_MTLO, MD_MUL, MD_MULT, MD_MULTU};
	end

	////////////////////////////////////////
	// Strobes
	////////////////////////////////////////

	// Legal command goes on and anything else turns into an error pulse
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out.valid <= 1'b0;
			cmd_error <= 1'b0;
		end
		else
		begin
			out.valid <= cmd_valid && op_legal;
			cmd_error <= cmd_valid && !op_legal;
		end
	end

	// Command payload
	always_ff @(posedge clk)
	begin
		if (cmd_valid)
		begin
			out.op <= cmd_op;
			out.rs <= cmd_rs;
			out.rt <= cmd_rt;
		end
	end

endmodule

// ==== design/md_cmd_if.sv ====
`timescale 1ns/10ps

// One command and its strobe between two blocks
interface md_cmd_if;
	import md_pkg::*;

	// Strobe for one cycle per delivered command
	logic valid;
	md_op_t op;
	// Operands as read from the register file
	word_t rs;
	word_t rt;

	// Block that delivers the command
	modport source
	(
		output valid,
		output op,
		output rs,
		output rt
	);

	// Block that takes the command
	modport sink
	(
		input valid,
		input op,
		input rs,
		input rt
	);

endinterface

// ==== design/md_pkg.sv ====
`include "md_config.svh"

package md_pkg;

	// One operand or result word
	typedef logic [`MD_WIDTH-1:0] word_t;

	// Full product or divider working register
	typedef logic [2*`MD_WIDTH-1:0] dword_t;

	// Operation code on the command path
	typedef logic [3:0] md_op_t;

	////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////
	localparam md_op_t MD_DIV   = 4'd1;
	localparam md_op_t MD_DIVU  = 4'd2;
	localparam md_op_t MD_MFHI  = 4'd3;
	localparam md_op_t MD_MFLO  = 4'd4;
	localparam md_op_t MD_MTHI  = 4'd5;
	localparam md_op_t MD_MTLO  = 4'd6;
	localparam md_op_t MD_MUL   = 4'd7;
	localparam md_op_t MD_MULT  = 4'd8;
	localparam md_op_t MD_MULTU = 4'd9;
	// Codes 0 and 10 through 15 are undefined

	// Execution unit state
	typedef enum logic
	{
		st_idle,
		st_divide
	} md_state_t;

endpackage

// ==== design/md_config.svh ====
`ifndef MD_CONFIG_SVH
`define MD_CONFIG_SVH

////////////////////////////////////////
// Multiply/divide unit dimensions
////////////////////////////////////////

// Operand and result width
`define MD_WIDTH 32

// Command entries held in the queue
// Power of two so the pointers wrap on their own
`define MD_QUEUE_DEPTH 4

// One divide iteration per quotient bit
`define MD_DIV_STEPS `MD_WIDTH

`endif
